// File: Makefile
SIM      := verilator
FLAGS    := --binary --timing --assert -Wno-fatal -j 0
TOP      := fprint_unit_tb
FILELIST := verilog.f

PASS     := Test completed successfully
OBJ_DIR  := obj_dir
BIN      := $(OBJ_DIR)/V$(TOP)
SOURCES  := $(filter-out +%,$(shell cat $(FILELIST))) fprint_macros.svh

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q "$(PASS)"

clean:
	rm -rf $(OBJ_DIR)

// File: comp_engine.sv
`timescale 1ns/100ps
`include "fprint_macros.svh"

module comp_engine (
	input  logic                        clk,
	input  logic                        reset,

	input  logic [`FP_TASK_COUNT-1:0]   ready,
	input  logic                        tails_at_heads,

	output fprint_pkg::task_id_t        comp_task,
	output logic                        tail_advance,
	output logic                        clear_req,
	output logic                        mismatch,
	input  logic                        clear_ack,

	output fprint_pkg::fp_addr_t        rd_addr0,
	output fprint_pkg::fp_addr_t        rd_addr1,
	input  fprint_pkg::fp_value_t       rd_data0,
	input  fprint_pkg::fp_value_t       rd_data1,
	input  fprint_pkg::fp_addr_t        tail_pointer0,
	input  fprint_pkg::fp_addr_t        tail_pointer1,

	output logic                        res_req,
	output fprint_pkg::task_id_t        res_task,
	output comp_pkg::verdict_e          res_verdict,
	input  logic                        res_ack
);

	comp_pkg::comp_state_e state;
	comp_pkg::verdict_e    verdict_q;

	fprint_pkg::task_id_t cur_task;    // task in service, also the round-robin start
	fprint_pkg::task_id_t pick_task;
	logic                 pick_valid;

	// first ready task at or after the one served last, wrapping around
	always_comb begin
		fprint_pkg::task_id_t cand;
		pick_valid = 1'b0;
		pick_task  = cur_task;
		for (int i = 0; i < `FP_TASK_COUNT; i++) begin
			cand = cur_task + fprint_pkg::task_id_t'(i);
			if (!pick_valid && ready[cand]) begin
				pick_valid = 1'b1;
				pick_task  = cand;
			end
		end
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state    <= comp_pkg::comp_scan;
			cur_task <= '0;
		end else begin
			case (state)
				comp_pkg::comp_scan: begin
					// the previous result handshake must be fully closed
					if (pick_valid && !res_ack) begin
						cur_task <= pick_task;
						state    <= comp_pkg::comp_read;
					end
				end
				comp_pkg::comp_read: begin
					if (tails_at_heads)   // flags still stale, nothing to compare
						state <= comp_pkg::comp_scan;
					else
						state <= comp_pkg::comp_compare;
				end
				comp_pkg::comp_compare:
					state <= comp_pkg::comp_report;
				comp_pkg::comp_report: begin
					if (res_ack)
						state <= comp_pkg::comp_retire;
				end
				comp_pkg::comp_retire:
					state <= comp_pkg::comp_wait_clear;
				comp_pkg::comp_wait_clear: begin
					if (clear_ack)
						state <= comp_pkg::comp_scan;
				end
				default:
					state <= comp_pkg::comp_scan;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == comp_pkg::comp_compare)
			verdict_q <= (rd_data0 == rd_data1) ? comp_pkg::verdict_match
				: comp_pkg::verdict_mismatch;
	end

	assign comp_task = cur_task;
	assign rd_addr0  = tail_pointer0;   // oldest unread entry of each core
	assign rd_addr1  = tail_pointer1;

	assign res_req     = (state == comp_pkg::comp_report);
	assign res_task    = cur_task;
	assign res_verdict = verdict_q;

	// a mismatch rewinds in the clear step instead of moving the tails
	assign tail_advance = (state == comp_pkg::comp_retire)
		&& (verdict_q == comp_pkg::verdict_match);
	assign clear_req = (state == comp_pkg::comp_wait_clear);
	assign mismatch  = (verdict_q == comp_pkg::verdict_mismatch);

endmodule

// File: comp_pkg.sv
package comp_pkg;

	// comparison engine sequencing for one pair of fingerprints
	typedef enum logic [2:0] {
		comp_scan,        // look for a task ready on both cores
		comp_read,        // tail addresses go to both RAMs
		comp_compare,     // registered RAM data is valid here
		comp_report,      // result handshake in progress
		comp_retire,
		comp_wait_clear   // ready flags being updated by the pointer block
	} comp_state_e;

	// result of one comparison as seen on res_verdict
	typedef enum logic {
		verdict_match    = 1'b0,
		verdict_mismatch = 1'b1
	} verdict_e;

endpackage

// File: comp_pointer_regs.sv
`timescale 1ns/100ps
`include "fprint_macros.svh"

module comp_pointer_regs (
	input  logic                            clk,
	input  logic                            reset,

	input  logic                            cfg_req,
	input  fprint_pkg::task_id_t            cfg_task,
	input  fprint_pkg::fp_addr_t            cfg_pointer,
	output logic                            cfg_ack,

	input  logic                            adv_req,
	input  logic                            adv_core,
	input  fprint_pkg::task_id_t            adv_task,
	output logic                            adv_ack,
	output fprint_pkg::fp_addr_t            head_pointer,

	input  fprint_pkg::task_id_t            comp_task,
	input  logic                            tail_advance,
	input  logic                            clear_req,
	input  logic                            mismatch,
	output logic                            clear_ack,

	output fprint_pkg::fp_addr_t            tail_pointer0,
	output fprint_pkg::fp_addr_t            tail_pointer1,
	output logic [`FP_TASK_COUNT-1:0]       ready,
	output logic                            tails_at_heads
);

	fprint_pkg::ptr_state_e state;

	// first index is the core, second the task
	fprint_pkg::fp_addr_t head_mem [0:1][0:`FP_TASK_COUNT-1];
	fprint_pkg::fp_addr_t tail_mem [0:1][0:`FP_TASK_COUNT-1];

	logic [1:0][`FP_TASK_COUNT-1:0] ready_mask;   // one mask per core
	logic [1:0] tail_eq_head;                      // per core, for comp_task
	logic rewind;

	// next entry inside the task's own region, the slot wraps on its own
	function automatic fprint_pkg::fp_addr_t next_in_region(fprint_pkg::task_id_t t,
			fprint_pkg::fp_addr_t p);
		logic [`FP_SLOT_WIDTH-1:0] slot;
		slot = p[`FP_SLOT_WIDTH-1:0] + 1'b1;
		return {t, slot};
	endfunction

	function automatic fprint_pkg::fp_addr_t region_start(fprint_pkg::task_id_t t);
		return {t, {`FP_SLOT_WIDTH{1'b0}}};
	endfunction

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state <= fprint_pkg::ptr_idle;
		end else begin
			case (state)
				fprint_pkg::ptr_idle: begin
					// configuration wins over head advance, which wins over clear
					if (cfg_req)
						state <= fprint_pkg::ptr_set_pointers;
					else if (adv_req)
						state <= fprint_pkg::ptr_advance_head;
					else if (clear_req)
						state <= fprint_pkg::ptr_clear_ready;
				end
				fprint_pkg::ptr_set_pointers:
					state <= fprint_pkg::ptr_ack_pointers;
				fprint_pkg::ptr_ack_pointers: begin
					if (!cfg_req)   // four-phase, hold the ack until req drops
						state <= fprint_pkg::ptr_idle;
				end
				fprint_pkg::ptr_advance_head:
					state <= fprint_pkg::ptr_idle;
				fprint_pkg::ptr_clear_ready:
					state <= fprint_pkg::ptr_idle;
				default:
					state <= fprint_pkg::ptr_idle;
			endcase
		end
	end

	assign cfg_ack   = (state == fprint_pkg::ptr_ack_pointers);
	assign adv_ack   = (state == fprint_pkg::ptr_advance_head);
	assign clear_ack = (state == fprint_pkg::ptr_clear_ready);
	assign rewind    = clear_ack && mismatch;

	// later assignments override earlier ones for the same entry
	always_ff @(posedge clk) begin
		for (int c = 0; c < 2; c++) begin
			if (tail_advance)
				tail_mem[c][comp_task] <= next_in_region(comp_task, tail_mem[c][comp_task]);
			if (rewind) begin
				// the task's stored fingerprints are dropped on both cores
				head_mem[c][comp_task] <= region_start(comp_task);
				tail_mem[c][comp_task] <= region_start(comp_task);
			end
			if (state == fprint_pkg::ptr_set_pointers) begin
				head_mem[c][cfg_task] <= cfg_pointer;
				tail_mem[c][cfg_task] <= cfg_pointer;
			end
		end
		if (state == fprint_pkg::ptr_advance_head)
			head_mem[adv_core][adv_task] <= next_in_region(adv_task, head_pointer);
	end

	assign head_pointer  = head_mem[adv_core][adv_task];
	assign tail_pointer0 = tail_mem[0][comp_task];
	assign tail_pointer1 = tail_mem[1][comp_task];

	assign tail_eq_head[0] = (tail_mem[0][comp_task] == head_mem[0][comp_task]);
	assign tail_eq_head[1] = (tail_mem[1][comp_task] == head_mem[1][comp_task]);
	assign tails_at_heads  = &tail_eq_head;

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			ready_mask <= '0;
		end else if (state == fprint_pkg::ptr_advance_head) begin
			ready_mask[adv_core][adv_task] <= 1'b1;
		end else if (clear_ack) begin
			// a core stays ready while it still has unread entries
			for (int c = 0; c < 2; c++) begin
				if (mismatch || tail_eq_head[c])
					ready_mask[c][comp_task] <= 1'b0;
			end
		end
	end

	assign ready = ready_mask[0] & ready_mask[1];   // a task needs entries from both cores

endmodule

// File: fprint_capture.sv
`timescale 1ns/100ps

module fprint_capture (
	input  logic                    clk,
	input  logic                    reset,

	input  logic                    fp_req,
	input  logic                    fp_core,
	input  fprint_pkg::task_id_t    fp_task,
	input  fprint_pkg::fp_value_t   fp_value,
	output logic                    fp_ack,

	output logic                    wr_en0,
	output logic                    wr_en1,
	output fprint_pkg::fp_addr_t    wr_addr,
	output fprint_pkg::fp_value_t   wr_data,

	output logic                    adv_req,
	output logic                    adv_core,
	output fprint_pkg::task_id_t    adv_task,
	input  logic                    adv_ack,
	input  fprint_pkg::fp_addr_t    head_pointer
);

	fprint_pkg::capture_state_e state;

	logic                  core_q;
	fprint_pkg::task_id_t  task_q;
	fprint_pkg::fp_value_t value_q;

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state <= fprint_pkg::cap_idle;
		end else begin
			case (state)
				fprint_pkg::cap_idle: begin
					if (fp_req)
						state <= fprint_pkg::cap_write;
				end
				fprint_pkg::cap_write:
					state <= fprint_pkg::cap_wait_advance;
				fprint_pkg::cap_wait_advance: begin
					if (adv_ack)   // one-cycle ack, adv_req falls next cycle
						state <= fprint_pkg::cap_ack;
				end
				fprint_pkg::cap_ack: begin
					if (!fp_req)
						state <= fprint_pkg::cap_idle;
				end
				default:
					state <= fprint_pkg::cap_idle;
			endcase
		end
	end

	// the core holds its data stable while req is high, so one sample is enough
	always_ff @(posedge clk) begin
		if (state == fprint_pkg::cap_idle && fp_req) begin
			core_q  <= fp_core;
			task_q  <= fp_task;
			value_q <= fp_value;
		end
	end

	// head_pointer follows adv_core and adv_task, so it is the slot to write
	assign adv_core = core_q;
	assign adv_task = task_q;
	assign wr_addr  = head_pointer;
	assign wr_data  = value_q;
	assign wr_en0   = (state == fprint_pkg::cap_write) && !core_q;
	assign wr_en1   = (state == fprint_pkg::cap_write) && core_q;

	assign adv_req = (state == fprint_pkg::cap_wait_advance);
	assign fp_ack  = (state == fprint_pkg::cap_ack);

endmodule

// File: fprint_macros.svh
`ifndef FPRINT_MACROS_SVH
`define FPRINT_MACROS_SVH

// number of tasks that can send fingerprints
`define FP_TASK_COUNT 16

// task id width, enough to index every task
`define FP_TASK_ID_WIDTH 4

// each task owns 2**FP_SLOT_WIDTH consecutive entries of a RAM
`define FP_SLOT_WIDTH 4

// RAM address is {task id, slot}
`define FP_ADDR_WIDTH 8

// width of one CRC fingerprint
`define FP_WIDTH 32

`endif

// File: fprint_pkg.sv
`include "fprint_macros.svh"

package fprint_pkg;

	typedef logic [`FP_TASK_ID_WIDTH-1:0] task_id_t;
	typedef logic [`FP_ADDR_WIDTH-1:0] fp_addr_t;   // upper bits task id, lower bits slot
	typedef logic [`FP_WIDTH-1:0] fp_value_t;

	// pointer block sequencing, one request served at a time
	typedef enum logic [2:0] {
		ptr_idle,
		ptr_set_pointers,
		ptr_ack_pointers,
		ptr_advance_head,
		ptr_clear_ready
	} ptr_state_e;

	typedef enum logic [1:0] {
		cap_idle,
		cap_write,
		cap_wait_advance,   // head advance requested, waiting for the pointer block
		cap_ack
	} capture_state_e;

endpackage

// File: fprint_ram.sv
`timescale 1ns/100ps
`include "fprint_macros.svh"

module fprint_ram (
	input  logic                    clk,

	input  logic                    wr_en,
	input  fprint_pkg::fp_addr_t    wr_addr,
	input  fprint_pkg::fp_value_t   wr_data,

	input  fprint_pkg::fp_addr_t    rd_addr,
	output fprint_pkg::fp_value_t   rd_data
);

	// one region of 2**FP_SLOT_WIDTH entries per task
	fprint_pkg::fp_value_t mem [0:(2**`FP_ADDR_WIDTH)-1];

	always_ff @(posedge clk) begin
		if (wr_en)
			mem[wr_addr] <= wr_data;
	end

	// registered read, data is valid the cycle after the address
	always_ff @(posedge clk) begin
		rd_data <= mem[rd_addr];
	end

endmodule

// File: fprint_unit_chk.sv
`timescale 1ns/100ps

module fprint_unit_chk (
	input logic clk,
	input logic reset,
	input logic cfg_req,
	input logic cfg_ack,
	input logic fp_req,
	input logic fp_ack,
	input logic adv_ack,
	input logic clear_ack,
	input logic res_req,
	input logic res_ack
);

	int failures = 0;   // count of failed assertions

	// every acknowledge and the result request come out of reset low
	reset_quiet: assert property (@(posedge clk)
		reset |=> !cfg_ack && !fp_ack && !adv_ack && !clear_ack && !res_req)
		else begin
			failures++;
			$error("handshake output high in the cycle after reset");
		end

	res_held: assert property (@(posedge clk) disable iff (reset)
		res_req && !res_ack |=> res_req)
		else begin
			failures++;
			$error("res_req dropped before res_ack");
		end

	// the requester may drop req as soon as it sees the ack, so req is taken from the edge
	// that raised the ack
	cfg_ack_rise: assert property (@(posedge clk) disable iff (reset)
		$rose(cfg_ack) |-> $past(cfg_req))
		else begin
			failures++;
			$error("cfg_ack rose without cfg_req");
		end

	fp_ack_rise: assert property (@(posedge clk) disable iff (reset)
		$rose(fp_ack) |-> $past(fp_req))
		else begin
			failures++;
			$error("fp_ack rose without fp_req");
		end

endmodule

bind fprint_unit_top fprint_unit_chk chk (
	.clk(clk), .reset(reset),
	.cfg_req(cfg_req), .cfg_ack(cfg_ack),
	.fp_req(fp_req), .fp_ack(fp_ack),
	.adv_ack(adv_ack), .clear_ack(clear_ack),
	.res_req(res_req), .res_ack(res_ack)
);

// File: fprint_unit_tb.sv
`timescale 1ns/100ps
`include "fprint_macros.svh"

module fprint_unit_tb;

	localparam int TIMEOUT_CYCLES = 400;

	logic                  clk;
	logic                  reset;
	logic                  cfg_req;
	fprint_pkg::task_id_t  cfg_task;
	fprint_pkg::fp_addr_t  cfg_pointer;
	logic                  cfg_ack;
	logic                  fp_req;
	logic                  fp_core;
	fprint_pkg::task_id_t  fp_task;
	fprint_pkg::fp_value_t fp_value;
	logic                  fp_ack;
	logic                  res_req;
	fprint_pkg::task_id_t  res_task;
	comp_pkg::verdict_e    res_verdict;
	logic                  res_ack = 1'b0;

	// fingerprints sent per core and per task, oldest first
	fprint_pkg::fp_value_t sent_q [0:1][0:`FP_TASK_COUNT-1][$];

	logic [31:0] stim_seed;
	logic [31:0] ack_seed;
	int errors = 0;
	int errors_at_start = 0;
	int checks = 0;
	int results = 0;
	int pairs_sent = 0;
	int test_count = 0;
	int ack_delay = 0;
	bit result_seen = 1'b0;
	bit task_fixed = 1'b0;      // set while only one task is in use
	fprint_pkg::task_id_t fixed_task;

	fprint_unit_top DUT (.*);

	always #5 clk = ~clk;

	function automatic logic [31:0] xorshift32(logic [31:0] s);
		logic [31:0] x;
		x = s ^ (s << 13);
		x = x ^ (x >> 17);
		return x ^ (x << 5);
	endfunction

	function automatic logic [31:0] draw_random();
		stim_seed = xorshift32(stim_seed);
		return stim_seed;
	endfunction

	// each task owns 2**FP_SLOT_WIDTH entries starting at {task, 0}
	function automatic fprint_pkg::fp_addr_t region_base(fprint_pkg::task_id_t t);
		return fprint_pkg::fp_addr_t'(t) << `FP_SLOT_WIDTH;
	endfunction

	function automatic comp_pkg::verdict_e predict_verdict(fprint_pkg::task_id_t t);
		fprint_pkg::fp_value_t a;
		fprint_pkg::fp_value_t b;
		a = sent_q[0][t].pop_front();
		b = sent_q[1][t].pop_front();
		if (a == b)
			return comp_pkg::verdict_match;
		sent_q[0][t].delete();   // the task is rewound and its entries are gone
		sent_q[1][t].delete();
		return comp_pkg::verdict_mismatch;
	endfunction

	task automatic check_verdict(comp_pkg::verdict_e got, comp_pkg::verdict_e exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAIL res_verdict: got 0x%0h, expected 0x%0h", got, exp);
		end
	endtask

	task automatic check_task(fprint_pkg::task_id_t got, fprint_pkg::task_id_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAIL res_task: got 0x%0h, expected 0x%0h", got, exp);
		end
	endtask

	task automatic check_count(int got, int exp);
		checks++;
		if (got != exp) begin
			errors++;
			$display("FAIL result count: got 0x%0h, expected 0x%0h", got, exp);
		end
	endtask

	task automatic step_clock();
		@(posedge clk);
		#1;
	endtask

	task automatic wait_ack(bit fp_side, logic level);
		int n;
		n = 0;
		while ((fp_side ? fp_ack : cfg_ack) !== level && n < TIMEOUT_CYCLES) begin
			step_clock();
			n++;
		end
		if ((fp_side ? fp_ack : cfg_ack) !== level) begin
			errors++;
			$display("timeout waiting for %s to go to %0d", fp_side ? "fp_ack" : "cfg_ack", level);
		end
	endtask

	task automatic configure_task(fprint_pkg::task_id_t t, fprint_pkg::fp_addr_t p);
		cfg_task = t;
		cfg_pointer = p;
		cfg_req = 1'b1;
		wait_ack(1'b0, 1'b1);
		cfg_req = 1'b0;
		wait_ack(1'b0, 1'b0);
	endtask

	task automatic send_fingerprint(logic core, fprint_pkg::task_id_t t, fprint_pkg::fp_value_t v);
		sent_q[core][t].push_back(v);
		fp_core = core;
		fp_task = t;
		fp_value = v;
		fp_req = 1'b1;
		wait_ack(1'b1, 1'b1);
		fp_req = 1'b0;
		wait_ack(1'b1, 1'b0);
	endtask

	task automatic send_pair(fprint_pkg::task_id_t t, fprint_pkg::fp_value_t v0,
			fprint_pkg::fp_value_t v1, bit core1_first);
		pairs_sent++;
		if (core1_first)
			send_fingerprint(1'b1, t, v1);
		send_fingerprint(1'b0, t, v0);
		if (!core1_first)
			send_fingerprint(1'b1, t, v1);
	endtask

	// waits for n results with their handshakes closed
	task automatic wait_for_results(int n);
		int k;
		k = 0;
		while ((results < n || res_req || res_ack) && k < TIMEOUT_CYCLES) begin
			step_clock();
			k++;
		end
		if (results < n || res_req || res_ack) begin
			errors++;
			$display("timeout waiting for result number %0d", n);
		end
		repeat (4) step_clock();   // retire, then clear or rewind in the pointer block
	endtask

	task automatic end_test(string name);
		test_count++;
		if (errors == errors_at_start)
			$display("test %0d %s: ok", test_count, name);
		else
			$display("test %0d %s: %0d errors", test_count, name, errors - errors_at_start);
		errors_at_start = errors;
	endtask

	// result side, sampled once the outputs have settled after the edge
	always @(posedge clk) begin
		#1;
		if (res_req && !res_ack) begin
			if (!result_seen) begin
				result_seen = 1'b1;
				results++;
				if (task_fixed)
					check_task(res_task, fixed_task);
				if (sent_q[0][res_task].size() == 0 || sent_q[1][res_task].size() == 0) begin
					errors++;
					$display("result for task %0d arrived without a pending pair", res_task);
				end else begin
					check_verdict(res_verdict, predict_verdict(res_task));
				end
				ack_seed = xorshift32(ack_seed);
				ack_delay = int'(ack_seed % 6);
			end
			if (ack_delay == 0)
				res_ack = 1'b1;
			else
				ack_delay--;
		end else if (!res_req && res_ack) begin
			res_ack = 1'b0;
			result_seen = 1'b0;
		end
	end

	initial begin
		fprint_pkg::fp_value_t vals [0:2];
		fprint_pkg::fp_value_t v;
		logic [31:0] r;
		clk = 1'b0;
		reset = 1'b1;
		cfg_req = 1'b0;
		cfg_task = '0;
		cfg_pointer = '0;
		fp_req = 1'b0;
		fp_core = 1'b0;
		fp_task = '0;
		fp_value = '0;
		stim_seed = 32'h0e0c7762;
		ack_seed = xorshift32(32'h0e0c7762);
		repeat (3) @(posedge clk);
		#1;
		reset = 1'b0;

		for (int i = 0; i < `FP_TASK_COUNT; i++)
			configure_task(fprint_pkg::task_id_t'(i), region_base(fprint_pkg::task_id_t'(i)));
		repeat (20) step_clock();
		check_count(results, 0);   // nothing stored, so nothing to compare
		end_test("configure all tasks");

		task_fixed = 1'b1;
		fixed_task = 4'd3;
		v = draw_random();
		send_pair(4'd3, v, v, 1'b0);
		wait_for_results(pairs_sent);
		check_count(results, pairs_sent);
		end_test("equal pair");

		fixed_task = 4'd5;
		v = draw_random();
		send_pair(4'd5, v, v ^ 32'h0000_0100, 1'b0);
		wait_for_results(pairs_sent);
		v = draw_random();
		send_pair(4'd5, v, v, 1'b1);
		wait_for_results(pairs_sent);
		check_count(results, pairs_sent);
		end_test("mismatch then match");

		fixed_task = 4'd7;
		for (int i = 0; i < 3; i++) begin
			vals[i] = draw_random();
			send_fingerprint(1'b0, 4'd7, vals[i]);
		end
		repeat (15) step_clock();
		check_count(results, pairs_sent);   // core 1 has sent nothing yet
		for (int i = 0; i < 3; i++)
			send_fingerprint(1'b1, 4'd7, vals[i]);
		pairs_sent += 3;
		wait_for_results(pairs_sent);
		check_count(results, pairs_sent);
		end_test("core 0 ahead by three");

		fixed_task = 4'd9;
		for (int i = 0; i < 20; i++) begin
			v = draw_random();
			send_pair(4'd9, v, v, i[0]);
			wait_for_results(pairs_sent);
		end
		check_count(results, pairs_sent);
		end_test("region wrap");

		task_fixed = 1'b0;
		for (int i = 0; i < 40; i++) begin
			r = draw_random();
			v = draw_random();
			if (r[7:5] == 3'd0) begin
				// a mismatch rewinds its task, so no other entries may be in flight
				wait_for_results(pairs_sent);
				send_pair(r[3:0], v, v ^ (32'h1 << r[12:8]), r[4]);
				wait_for_results(pairs_sent);
			end else begin
				send_pair(r[3:0], v, v, r[4]);
			end
		end
		wait_for_results(pairs_sent);
		check_count(results, pairs_sent);
		end_test("random traffic");

		errors += DUT.chk.failures;
		$display("tests %0d, checks %0d, results %0d, errors %0d",
			test_count, checks, results, errors);
		if (errors == 0)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end

endmodule

// File: fprint_unit_top.sv
`timescale 1ns/100ps
`include "fprint_macros.svh"

module fprint_unit_top (
	input  logic                    clk,
	input  logic                    reset,

	input  logic                    cfg_req,
	input  fprint_pkg::task_id_t    cfg_task,
	input  fprint_pkg::fp_addr_t    cfg_pointer,
	output logic                    cfg_ack,

	input  logic                    fp_req,
	input  logic                    fp_core,
	input  fprint_pkg::task_id_t    fp_task,
	input  fprint_pkg::fp_value_t   fp_value,
	output logic                    fp_ack,

	output logic                    res_req,
	output fprint_pkg::task_id_t    res_task,
	output comp_pkg::verdict_e      res_verdict,
	input  logic                    res_ack
);

	logic                  adv_req;
	logic                  adv_core;
	fprint_pkg::task_id_t  adv_task;
	logic                  adv_ack;
	fprint_pkg::fp_addr_t  head_pointer;

	fprint_pkg::task_id_t  comp_task;
	logic                  tail_advance;
	logic                  clear_req;
	logic                  mismatch;
	logic                  clear_ack;
	fprint_pkg::fp_addr_t  tail_pointer0;
	fprint_pkg::fp_addr_t  tail_pointer1;
	logic [`FP_TASK_COUNT-1:0] ready;
	logic                  tails_at_heads;

	logic                  wr_en0;
	logic                  wr_en1;
	fprint_pkg::fp_addr_t  wr_addr;
	fprint_pkg::fp_value_t wr_data;
	fprint_pkg::fp_addr_t  rd_addr0;
	fprint_pkg::fp_addr_t  rd_addr1;
	fprint_pkg::fp_value_t rd_data0;
	fprint_pkg::fp_value_t rd_data1;

	comp_pointer_regs u_pointer_regs (
		.clk(clk), .reset(reset),
		.cfg_req(cfg_req), .cfg_task(cfg_task), .cfg_pointer(cfg_pointer), .cfg_ack(cfg_ack),
		.adv_req(adv_req), .adv_core(adv_core), .adv_task(adv_task), .adv_ack(adv_ack),
		.head_pointer(head_pointer),
		.comp_task(comp_task), .tail_advance(tail_advance), .clear_req(clear_req),
		.mismatch(mismatch), .clear_ack(clear_ack),
		.tail_pointer0(tail_pointer0), .tail_pointer1(tail_pointer1),
		.ready(ready), .tails_at_heads(tails_at_heads)
	);

	fprint_capture u_capture (
		.clk(clk), .reset(reset),
		.fp_req(fp_req), .fp_core(fp_core), .fp_task(fp_task), .fp_value(fp_value),
		.fp_ack(fp_ack),
		.wr_en0(wr_en0), .wr_en1(wr_en1), .wr_addr(wr_addr), .wr_data(wr_data),
		.adv_req(adv_req), .adv_core(adv_core), .adv_task(adv_task), .adv_ack(adv_ack),
		.head_pointer(head_pointer)
	);

	comp_engine u_engine (
		.clk(clk), .reset(reset),
		.ready(ready), .tails_at_heads(tails_at_heads),
		.comp_task(comp_task), .tail_advance(tail_advance), .clear_req(clear_req),
		.mismatch(mismatch), .clear_ack(clear_ack),
		.rd_addr0(rd_addr0), .rd_addr1(rd_addr1), .rd_data0(rd_data0), .rd_data1(rd_data1),
		.tail_pointer0(tail_pointer0), .tail_pointer1(tail_pointer1),
		.res_req(res_req), .res_task(res_task), .res_verdict(res_verdict), .res_ack(res_ack)
	);

	// core 0 fingerprints
	fprint_ram u_ram0 (
		.clk(clk), .wr_en(wr_en0), .wr_addr(wr_addr), .wr_data(wr_data),
		.rd_addr(rd_addr0), .rd_data(rd_data0)
	);

	// core 1 fingerprints
	fprint_ram u_ram1 (
		.clk(clk), .wr_en(wr_en1), .wr_addr(wr_addr), .wr_data(wr_data),
		.rd_addr(rd_addr1), .rd_data(rd_data1)
	);

endmodule

// File: verilog.f
+incdir+.
fprint_pkg.sv
comp_pkg.sv
fprint_ram.sv
comp_pointer_regs.sv
fprint_capture.sv
comp_engine.sv
fprint_unit_top.sv
fprint_unit_chk.sv
fprint_unit_tb.sv
